// File: design/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// --------------------
// Memory map

// Internal RAM sits at the top of the address space and echoes above 8 KB
`define SOC_RAM_BASE    32'hFFFF_0000

// GPIO register block
`define SOC_GPIO_BASE   32'h0300_0000
`define SOC_GPIO_SIZE   32'h0000_0100

// Single transmit data word
`define SOC_UART_ADDR   32'h0300_0100

// --------------------
// Internal RAM

`define SOC_RAM_WORDS   2048        // 8 KB of 32-bit words

// --------------------
// GPIO word indices taken from address bits 5:2

`define GPIO_DELAY      4'd0        // Read gives delay detect and write sets delay select
`define GPIO_LED        4'd1        // Bit 0 red, bit 1 green, bit 2 blue
`define GPIO_Z80RST     4'd3
`define GPIO_SCL        4'd5
`define GPIO_SDA        4'd6        // Reads back the pin instead of the register
`define GPIO_USBRST     4'd7        // Active low USB reset

// --------------------
// Serial transmitter

`define SOC_UART_DIV    8           // Clocks per serial bit

`endif

// File: design/soc_pkg.sv
package soc_pkg;

    // --------------------
    // System bus

    // Request from the bus master where a zero wstrb means read
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } bus_req_t;

    // Reply formed by the fabric
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } bus_rsp_t;

    // Decoded target of the lookahead address
    typedef enum logic [1:0] {
        REG_NONE = 2'd0,
        REG_RAM  = 2'd1,
        REG_GPIO = 2'd2,
        REG_UART = 2'd3
    } region_t;

endpackage

// File: design/bus_decoder.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module bus_decoder (
    input  logic              clk_rv,
    input  logic              rst_rv,
    input  logic [31:0]       la_addr,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp,
    output soc_pkg::bus_req_t ram_req,
    output soc_pkg::bus_req_t gpio_req,
    output soc_pkg::bus_req_t uart_req,
    input  logic [31:0]       ram_rdata,
    input  logic [31:0]       gpio_rdata,
    input  logic              uart_ready,
    output logic              bus_error
);

    soc_pkg::region_t la_region;
    soc_pkg::region_t region;        // Registered select
    logic             default_ready;
    logic             valid_last;
    logic             bus_ready;
    logic             req_live;      // Valid and not yet acknowledged

    // --------------------
    // Lookahead decode

    always_comb begin
        if (la_addr >= `SOC_RAM_BASE) begin
            la_region = soc_pkg::REG_RAM;
        end else if (la_addr >= `SOC_GPIO_BASE &&
                     la_addr < (`SOC_GPIO_BASE + `SOC_GPIO_SIZE)) begin
            la_region = soc_pkg::REG_GPIO;
        end else if (la_addr == `SOC_UART_ADDR) begin
            la_region = soc_pkg::REG_UART;
        end else begin
            la_region = soc_pkg::REG_NONE;
        end
    end

    // Region follows the lookahead address between requests
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            region <= soc_pkg::REG_NONE;
        end else if (!req.valid) begin
            region <= la_region;
        end
    end

    // --------------------
    // Target selects

    assign bus_ready = default_ready | uart_ready;
    assign req_live  = req.valid & ~bus_ready;

    always_comb begin
        ram_req        = req;
        gpio_req       = req;
        uart_req       = req;
        ram_req.valid  = req_live && (region == soc_pkg::REG_RAM);
        gpio_req.valid = req_live && (region == soc_pkg::REG_GPIO);
        uart_req.valid = req_live && (region == soc_pkg::REG_UART);
    end

    // One cycle acknowledge for everything except the UART
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            default_ready <= 1'b0;
        end else begin
            default_ready <= req_live && (region != soc_pkg::REG_UART);
        end
    end

    // --------------------
    // Sticky bus error

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            valid_last <= 1'b0;
            bus_error  <= 1'b0;
        end else begin
            valid_last <= req.valid;
            if (req.valid && !valid_last && region == soc_pkg::REG_NONE) begin
                bus_error <= 1'b1;
            end
        end
    end

    // --------------------
    // Read return

    always_comb begin
        rsp.ready = bus_ready;
        case (region)
            soc_pkg::REG_RAM:  rsp.rdata = ram_rdata;
            soc_pkg::REG_GPIO: rsp.rdata = gpio_rdata;
            default:           rsp.rdata = 32'hFFFF_FFFF;  // Unmapped or write-only
        endcase
    end

    // Only one target acknowledges at a time
    a_one_target: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        !(default_ready && uart_ready));

endmodule

// File: design/soc_sram.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_sram (
    input  logic              clk_rv,
    input  soc_pkg::bus_req_t req,
    output logic [31:0]       rdata
);

    localparam int AW = $clog2(`SOC_RAM_WORDS);

    logic [31:0]   mem [`SOC_RAM_WORDS];
    logic [AW-1:0] idx;

    assign idx = req.addr[AW+1:2];  // Upper bits echo

    // Byte lane writes
    always_ff @(posedge clk_rv) begin
        for (int i = 0; i < 4; i++) begin
            if (req.valid && req.wstrb[i]) begin
                mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
            end
        end
    end

    // Registered read on every clock
    always_ff @(posedge clk_rv) begin
        rdata <= mem[idx];
    end

endmodule

// File: design/gpio_regs.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module gpio_regs (
    input  logic              clk_rv,
    input  logic              rst_rv,
    input  soc_pkg::bus_req_t req,
    input  logic [4:0]        delay_det,
    input  logic              sda_in,
    output logic [31:0]       rdata,
    output logic [2:0]        led,
    output logic              z80_rst,
    output logic              scl,
    output logic              sda_oe,
    output logic              usb_rst_n,
    output logic [4:0]        delay_sel
);

    logic       sda;     // High releases the line
    logic [3:0] idx;
    logic       wr;
    logic       rd;

    assign idx = req.addr[5:2];
    assign wr  = req.valid && (req.wstrb != 4'b0000);
    assign rd  = req.valid && (req.wstrb == 4'b0000);

    // --------------------
    // Register writes

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            led       <= 3'b000;
            z80_rst   <= 1'b1;        // Hold the Z80 in reset
            scl       <= 1'b1;
            sda       <= 1'b1;
            usb_rst_n <= 1'b0;
            delay_sel <= delay_det;   // Start from the detected delay
        end else if (wr) begin
            case (idx)
                `GPIO_DELAY:  delay_sel <= req.wdata[4:0];
                `GPIO_LED:    led       <= req.wdata[2:0];
                `GPIO_Z80RST: z80_rst   <= req.wdata[0];
                `GPIO_SCL:    scl       <= req.wdata[0];
                `GPIO_SDA:    sda       <= req.wdata[0];
                `GPIO_USBRST: usb_rst_n <= req.wdata[0];
                default: ;
            endcase
        end
    end

    // --------------------
    // Readback

    always_ff @(posedge clk_rv) begin
        if (rd) begin
            case (idx)
                `GPIO_DELAY:  rdata <= {27'd0, delay_det};
                `GPIO_LED:    rdata <= {29'd0, led};
                `GPIO_Z80RST: rdata <= {31'd0, z80_rst};
                `GPIO_SDA:    rdata <= {31'd0, sda_in};  // Pin state
                default:      rdata <= 32'd0;
            endcase
        end
    end

    assign sda_oe = ~sda;  // Open drain that only drives low

    // A bus access reaches the registers for one cycle only
    a_single_access: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        req.valid |=> !req.valid);

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module uart_tx (
    input  logic              clk_rv,
    input  logic              rst_rv,
    input  soc_pkg::bus_req_t req,
    output logic              ready,
    output logic              txd
);

    localparam int DIV   = `SOC_UART_DIV;
    localparam int DIV_W = $clog2(DIV);

    logic             busy;
    logic [8:0]       shift;     // Stop bit above the data byte
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;   // 0 start, 1 to 8 data, 9 stop
    logic             bit_end;

    assign bit_end = (div_cnt == DIV_W'(DIV - 1));

    // --------------------
    // Bit timing and line

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            busy    <= 1'b0;
            ready   <= 1'b0;
            txd     <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= 4'd0;
        end else begin
            ready <= 1'b0;
            if (!busy) begin
                if (req.valid) begin
                    busy    <= 1'b1;
                    txd     <= 1'b0;          // Start bit
                    div_cnt <= '0;
                    bit_cnt <= 4'd0;
                end
            end else if (bit_end) begin
                div_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy  <= 1'b0;            // Stop bit done
                    ready <= 1'b1;
                end else begin
                    txd     <= shift[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Data shifter sending LSB first
    always_ff @(posedge clk_rv) begin
        if (!busy && req.valid) begin
            shift <= {1'b1, req.wdata[7:0]};
        end else if (busy && bit_end) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

    a_idle_high: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        !busy |-> txd);

endmodule

// File: design/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic              clk_rv,
    input  logic              rst_rv,
    input  logic [31:0]       la_addr,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp,
    input  logic [4:0]        delay_det,
    input  logic              sda_in,
    output logic [2:0]        led,
    output logic              z80_rst,
    output logic              scl,
    output logic              sda_oe,
    output logic              usb_rst_n,
    output logic [4:0]        delay_sel,
    output logic              txd,
    output logic              bus_error
);

    soc_pkg::bus_req_t ram_req;
    soc_pkg::bus_req_t gpio_req;
    soc_pkg::bus_req_t uart_req;
    logic [31:0]       ram_rdata;
    logic [31:0]       gpio_rdata;
    logic              uart_ready;

    // --------------------
    // Fabric

    bus_decoder i_decoder (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .la_addr    (la_addr),
        .req        (req),
        .rsp        (rsp),
        .ram_req    (ram_req),
        .gpio_req   (gpio_req),
        .uart_req   (uart_req),
        .ram_rdata  (ram_rdata),
        .gpio_rdata (gpio_rdata),
        .uart_ready (uart_ready),
        .bus_error  (bus_error)
    );

    // --------------------
    // Targets

    soc_sram i_sram (
        .clk_rv (clk_rv),
        .req    (ram_req),
        .rdata  (ram_rdata)
    );

    gpio_regs i_gpio (
        .clk_rv    (clk_rv),
        .rst_rv    (rst_rv),
        .req       (gpio_req),
        .delay_det (delay_det),
        .sda_in    (sda_in),
        .rdata     (gpio_rdata),
        .led       (led),
        .z80_rst   (z80_rst),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .usb_rst_n (usb_rst_n),
        .delay_sel (delay_sel)
    );

    uart_tx i_uart (
        .clk_rv (clk_rv),
        .rst_rv (rst_rv),
        .req    (uart_req),
        .ready  (uart_ready),
        .txd    (txd)
    );

endmodule

// File: tb/soc_bus_checker.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_bus_checker (
    input  logic              clk_rv,
    input  logic              rst_rv,
    input  soc_pkg::bus_req_t req,
    input  soc_pkg::bus_rsp_t rsp,
    input  logic [4:0]        delay_det,
    input  logic              sda_in,
    input  logic [2:0]        led,
    input  logic              z80_rst,
    input  logic              scl,
    input  logic              sda_oe,
    input  logic              usb_rst_n,
    input  logic [4:0]        delay_sel,
    input  logic              txd,
    input  logic              bus_error,
    output int                mismatches,
    output int                failures,
    output int                done_count
);

    localparam int DIV = `SOC_UART_DIV;

    logic [31:0]      ram_shadow [`SOC_RAM_WORDS];
    logic [3:0]       ram_known  [`SOC_RAM_WORDS];   // Byte lanes written since reset
    logic [2:0]       exp_led;
    logic             exp_z80;
    logic             exp_scl;
    logic             exp_sda;
    logic             exp_usb;
    logic [4:0]       exp_delay;
    logic             exp_err;
    logic             valid_q;
    logic             in_flight;
    int               age;
    soc_pkg::region_t cur_region;
    logic [31:0]      exp_rdata;
    logic [31:0]      exp_mask;
    logic [7:0]       tx_bytes [$];                  // Bytes written but not yet seen on txd
    logic             rx_busy;
    int               rx_cnt;
    logic [9:0]       rx_frame;
    int               mismatch_cnt = 0;
    int               fail_cnt = 0;
    int               done_cnt = 0;

    assign mismatches = mismatch_cnt;
    assign failures   = fail_cnt;
    assign done_count = done_cnt;

    task automatic report_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        mismatch_cnt++;
        $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic report_failure(input string msg);
        fail_cnt++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    function automatic soc_pkg::region_t map_region(input logic [31:0] a);
        if (a >= `SOC_RAM_BASE) return soc_pkg::REG_RAM;
        if (a >= `SOC_GPIO_BASE && a < `SOC_GPIO_BASE + `SOC_GPIO_SIZE) return soc_pkg::REG_GPIO;
        if (a == `SOC_UART_ADDR) return soc_pkg::REG_UART;
        return soc_pkg::REG_NONE;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] lanes);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{lanes[i]}};
        end
        return m;
    endfunction

    // --------------------
    // Static outputs

    task automatic check_outputs();
        if (led !== exp_led)         report_value("led", 32'(led), 32'(exp_led));
        if (z80_rst !== exp_z80)     report_value("z80_rst", 32'(z80_rst), 32'(exp_z80));
        if (scl !== exp_scl)         report_value("scl", 32'(scl), 32'(exp_scl));
        if (sda_oe !== ~exp_sda)     report_value("sda_oe", 32'(sda_oe), 32'(!exp_sda));
        if (usb_rst_n !== exp_usb)   report_value("usb_rst_n", 32'(usb_rst_n), 32'(exp_usb));
        if (delay_sel !== exp_delay) report_value("delay_sel", 32'(delay_sel), 32'(exp_delay));
        if (bus_error !== exp_err)   report_value("bus_error", 32'(bus_error), 32'(exp_err));
    endtask

    // --------------------
    // Serial line decoder sampling the middle of each bit

    task automatic decode_serial();
        logic [7:0] want;
        if (!rx_busy) begin
            if (txd !== 1'b1) begin
                rx_busy = 1'b1;
                rx_cnt  = 0;
                if (tx_bytes.size() == 0) report_failure("start bit on txd with no UART write");
            end
        end else begin
            rx_cnt++;
            if (rx_cnt % DIV == DIV / 2) begin
                rx_frame = {txd, rx_frame[9:1]};
            end
            if (rx_cnt == DIV / 2 + 9 * DIV) begin
                rx_busy = 1'b0;
                if (rx_frame[0] !== 1'b0 || rx_frame[9] !== 1'b1) begin
                    report_failure("serial frame with a bad start or stop bit");
                end
                if (tx_bytes.size() > 0) begin
                    want = tx_bytes.pop_front();
                    if (rx_frame[8:1] !== want) report_value("txd byte", 32'(rx_frame[8:1]),
                                                             32'(want));
                end
            end
        end
    endtask

    // --------------------
    // Handshake and read data

    task automatic check_response();
        if (in_flight) age++;
        if (rsp.ready) begin
            if (!in_flight || req.valid !== 1'b1) begin
                report_failure("ready raised with no request pending");
            end else begin
                if (cur_region == soc_pkg::REG_UART && (rx_busy || tx_bytes.size() != 0)) begin
                    report_failure("UART ready came before the stop bit ended");
                end
                if ((rsp.rdata & exp_mask) !== (exp_rdata & exp_mask)) begin
                    report_value("rdata", rsp.rdata, exp_rdata);
                end
                done_cnt++;
            end
            in_flight = 1'b0;
        end else if (in_flight && cur_region != soc_pkg::REG_UART && age >= 1) begin
            report_failure("no ready one cycle after valid rose");
            in_flight = 1'b0;
        end
    endtask

    // New request seen on the first valid cycle
    task automatic accept_request();
        logic [10:0] idx;
        logic [3:0]  gidx;
        cur_region = map_region(req.addr);
        in_flight  = 1'b1;
        age        = 0;
        exp_mask   = 32'd0;
        exp_rdata  = 32'd0;
        idx        = req.addr[12:2];
        gidx       = req.addr[5:2];
        case (cur_region)
            soc_pkg::REG_RAM: begin
                if (req.wstrb != 4'b0000) begin
                    for (int i = 0; i < 4; i++) begin
                        if (req.wstrb[i]) begin
                            ram_shadow[idx][8*i +: 8] = req.wdata[8*i +: 8];
                            ram_known[idx][i]         = 1'b1;
                        end
                    end
                end else begin
                    exp_rdata = ram_shadow[idx];
                    exp_mask  = lane_mask(ram_known[idx]);   // Never written bytes skipped
                end
            end
            soc_pkg::REG_GPIO: begin
                if (req.wstrb != 4'b0000) begin
                    case (gidx)
                        `GPIO_DELAY:  exp_delay = req.wdata[4:0];
                        `GPIO_LED:    exp_led   = req.wdata[2:0];
                        `GPIO_Z80RST: exp_z80   = req.wdata[0];
                        `GPIO_SCL:    exp_scl   = req.wdata[0];
                        `GPIO_SDA:    exp_sda   = req.wdata[0];
                        `GPIO_USBRST: exp_usb   = req.wdata[0];
                        default: ;
                    endcase
                end else begin
                    exp_mask = 32'hFFFF_FFFF;
                    case (gidx)
                        `GPIO_DELAY:  exp_rdata = {27'd0, delay_det};
                        `GPIO_LED:    exp_rdata = {29'd0, exp_led};
                        `GPIO_Z80RST: exp_rdata = {31'd0, exp_z80};
                        `GPIO_SDA:    exp_rdata = {31'd0, sda_in};
                        default:      exp_rdata = 32'd0;
                    endcase
                end
            end
            soc_pkg::REG_UART: tx_bytes.push_back(req.wdata[7:0]);
            default: begin
                exp_err   = 1'b1;
                exp_mask  = 32'hFFFF_FFFF;
                exp_rdata = 32'hFFFF_FFFF;
            end
        endcase
    endtask

    // Compare before the model moves because the DUT updates on the same edge
    always @(posedge clk_rv) begin
        if (!rst_rv) begin
            exp_led   = 3'b000;
            exp_z80   = 1'b1;
            exp_scl   = 1'b1;
            exp_sda   = 1'b1;
            exp_usb   = 1'b0;
            exp_delay = delay_det;
            exp_err   = 1'b0;
            in_flight = 1'b0;
            rx_busy   = 1'b0;
            rx_frame  = 10'd0;
            tx_bytes.delete();
            for (int i = 0; i < `SOC_RAM_WORDS; i++) begin
                ram_known[i] = 4'b0000;
            end
        end else begin
            check_outputs();
            decode_serial();
            check_response();
            if (req.valid && !valid_q) accept_request();
        end
        valid_q = rst_rv && req.valid;
    end

endmodule

// File: tb/tb_soc_bus.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module tb_soc_bus;

    localparam int NUM_TXN     = 400;
    localparam int RESET_CYC   = 4;
    localparam int TIMEOUT_CYC = NUM_TXN * (10 * `SOC_UART_DIV + 4) + RESET_CYC;

    logic              clk_rv = 1'b0;
    logic              rst_rv;
    logic [31:0]       la_addr;
    soc_pkg::bus_req_t req;
    soc_pkg::bus_rsp_t rsp;
    logic [4:0]        delay_det;
    logic              sda_in;
    logic [2:0]        led;
    logic              z80_rst;
    logic              scl;
    logic              sda_oe;
    logic              usb_rst_n;
    logic [4:0]        delay_sel;
    logic              txd;
    logic              bus_error;

    int                mismatches;
    int                failures;
    int                done_count;
    int                short_run;
    int                cycle_cnt = 0;
    logic [31:0]       lcg_state = 32'hcb50;

    always #50 clk_rv = ~clk_rv;    // 100 ns period

    soc_bus_top i_dut (
        .clk_rv    (clk_rv),
        .rst_rv    (rst_rv),
        .la_addr   (la_addr),
        .req       (req),
        .rsp       (rsp),
        .delay_det (delay_det),
        .sda_in    (sda_in),
        .led       (led),
        .z80_rst   (z80_rst),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .usb_rst_n (usb_rst_n),
        .delay_sel (delay_sel),
        .txd       (txd),
        .bus_error (bus_error)
    );

    soc_bus_checker i_checker (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .req        (req),
        .rsp        (rsp),
        .delay_det  (delay_det),
        .sda_in     (sda_in),
        .led        (led),
        .z80_rst    (z80_rst),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .usb_rst_n  (usb_rst_n),
        .delay_sel  (delay_sel),
        .txd        (txd),
        .bus_error  (bus_error),
        .mismatches (mismatches),
        .failures   (failures),
        .done_count (done_count)
    );

    // --------------------
    // Random numbers

    function automatic logic [15:0] lcg_step();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];    // Low bits of an LCG repeat quickly
    endfunction

    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        hi = lcg_step();
        return {hi, lcg_step()};
    endfunction

    // --------------------
    // Bus master

    // Lookahead address one cycle ahead of valid and valid held until ready
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb);
        logic [31:0] noise;
        noise = rand32();
        @(negedge clk_rv);
        req.valid = 1'b0;
        la_addr   = addr;
        delay_det = noise[4:0];
        sda_in    = noise[8];
        @(negedge clk_rv);
        req.valid = 1'b1;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = wstrb;
        do begin
            @(negedge clk_rv);
        end while (rsp.ready !== 1'b1);
    endtask

    task automatic random_txn();
        logic [31:0] r;
        logic [31:0] wdata;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        int          sel;
        r     = rand32();
        wdata = rand32();
        sel   = int'(r[15:0] % 16'd100);
        wstrb = r[28] ? r[27:24] : 4'b0000;
        if (sel < 40) begin
            // 32 RAM words with random echo bits above the 8 KB
            addr = `SOC_RAM_BASE | {16'd0, r[18:16], 6'd0, r[23:19], 2'b00};
        end else if (sel < 70) begin
            addr = `SOC_GPIO_BASE | {24'd0, r[17:16], r[21:18], 2'b00};
        end else if (sel < 92) begin
            addr  = `SOC_UART_ADDR;
            wstrb = r[27:24] | 4'b0001;    // UART is write only
        end else if (r[29]) begin
            addr = {4'h1, wdata[27:2], 2'b00};
        end else begin
            addr = 32'h0300_0104 + {24'd0, wdata[7:2], 2'b00};  // Just above the UART
        end
        bus_access(addr, wdata, wstrb);
    endtask

    // --------------------
    // Run control

    always @(posedge clk_rv) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles, the bus master never saw the last ready",
                     cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] boot;
        boot      = rand32();
        rst_rv    = 1'b0;
        la_addr   = 32'd0;
        req       = '0;
        delay_det = boot[4:0];
        sda_in    = 1'b1;
        short_run = 0;
        repeat (RESET_CYC) @(negedge clk_rv);
        rst_rv = 1'b1;

        for (int i = 0; i < NUM_TXN; i++) begin
            random_txn();
        end
        @(negedge clk_rv);
        req.valid = 1'b0;
        repeat (4) @(negedge clk_rv);

        if (done_count != NUM_TXN) begin
            $display("Only %0d of %0d transactions were acknowledged", done_count, NUM_TXN);
            short_run = 1;
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d transactions checked",
                 mismatches, failures + short_run, done_count);
        if (mismatches + failures + short_run == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+design
design/soc_pkg.sv
design/bus_decoder.sv
design/soc_sram.sv
design/gpio_regs.sv
design/uart_tx.sv
design/soc_bus_top.sv
tb/soc_bus_checker.sv
tb/tb_soc_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_soc_bus -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_soc_bus)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
